//--- flist.f
+incdir+.
dispatch_pkg.sv
mem_req_if.sv
dispatch_ctl.sv
cpu_slot_table.sv
proc_table.sv
shared_mem.sv
cpu_dispatch_top.sv
tb_cpu_dispatch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu_dispatch -o sim_cpu_dispatch
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_cpu_dispatch)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- tb_cpu_dispatch.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module tb_cpu_dispatch;
  import dispatch_pkg::*;

  logic                  clk;
  logic                  ext_rst_e;
  logic                  proc_load;
  logic [`ADDR_W-1:0]    proc_entry;
  logic                  cpu_rst;
  logic [`CPU_IDX_W-1:0] cpu_rst_idx;
  logic                  cpu_q;
  logic                  cpu_active;
  logic [`CPU_IDX_W-1:0] cpu_index;
  logic [`ADDR_W-1:0]    cpu_entry;
  logic                  cpu_e;
  cpu_msg_e              cpu_msg;
  logic                  read_q;
  logic                  write_q;
  logic [`ADDR_W-1:0]    req_addr;
  logic [`DATA_W-1:0]    req_wdata;
  logic                  read_dn;
  logic                  write_dn;
  logic [`DATA_W-1:0]    rd_data;

  integer seed;
  int     checks;
  int     errors;
  int     err_mark;
  int     offers;
  bit     timed_out;

  // scheduler and process table model
  int                 m_active;
  int                 m_free;
  int                 m_run;
  bit                 m_last_free;
  int                 m_sel;
  int                 loaded;
  logic [`ADDR_W-1:0] ent [`PROC_QUANTITY];
  // shared memory model
  logic [`DATA_W-1:0] mem_model [`MEM_DEPTH];
  logic [`ADDR_W-1:0] addrs [$];

  cpu_dispatch_top cpu_dispatch_top_inst (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .proc_load   (proc_load),
    .proc_entry  (proc_entry),
    .cpu_rst     (cpu_rst),
    .cpu_rst_idx (cpu_rst_idx),
    .cpu_q       (cpu_q),
    .cpu_active  (cpu_active),
    .cpu_index   (cpu_index),
    .cpu_entry   (cpu_entry),
    .cpu_e       (cpu_e),
    .cpu_msg     (cpu_msg),
    .read_q      (read_q),
    .write_q     (write_q),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .read_dn     (read_dn),
    .write_dn    (write_dn),
    .rd_data     (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // expected offer as {active, index}
  function automatic logic [`CPU_IDX_W:0] predict_offer(input int act, input int fre,
                                                        input int run, input bit last_free);
    int nxt;
    if ((fre > 0 && !last_free) || act == 0) begin
      return '0;
    end
    nxt = (run + 1 >= act) ? 0 : run + 1;
    return {1'b1, `CPU_IDX_W'(nxt)};
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (!timed_out) begin
      checks++;
      if (got !== exp) begin
        errors++;
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d mismatches", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // compare one offer with the model and step the model
  task automatic check_offer();
    logic [`CPU_IDX_W:0] exp_offer;
    exp_offer = predict_offer(m_active, m_free, m_run, m_last_free);
    check_val("offer active flag", 32'(cpu_active), 32'(exp_offer[`CPU_IDX_W]));
    check_val("offer slot index", 32'(cpu_index), 32'(exp_offer[`CPU_IDX_W-1:0]));
    check_val("offer entry", 32'(cpu_entry), 32'(ent[`PROC_IDX_W'(m_sel)]));
    if (exp_offer[`CPU_IDX_W]) begin
      m_run       = int'(exp_offer[`CPU_IDX_W-1:0]);
      m_last_free = 1'b0;
    end else begin
      m_last_free = 1'b1;
    end
    m_sel = (m_sel + 1 >= loaded) ? 0 : m_sel + 1;
    offers++;
  endtask

  task automatic wait_offer();
    int n;
    n = 0;
    @(negedge clk);
    while (!cpu_q && n < 40 && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (cpu_q) begin
      check_offer();
    end else if (!timed_out) begin
      timed_out = 1'b1;
      $display("timeout: no slice offer arrived within 40 cycles");
    end
  endtask

  // lat counts falling edges from the drive edge
  task automatic wait_done(output int lat);
    lat = 1;
    @(negedge clk);
    while (!(read_dn || write_dn) && lat < 20 && !timed_out) begin
      @(negedge clk);
      lat++;
    end
    if (!(read_dn || write_dn) && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: no read or write completion within 20 cycles");
    end
  endtask

  task automatic mem_access(input bit rd, input bit wr, input logic [`ADDR_W-1:0] a,
                            input logic [`DATA_W-1:0] d);
    int lat;
    @(posedge clk);
    read_q    <= rd;
    write_q   <= wr;
    req_addr  <= a;
    req_wdata <= d;
    wait_done(lat);
    // taken one edge after the drive and done two edges later
    check_val("done latency", 32'(lat), 32'd4);
    if (rd) begin
      check_val("read_dn", 32'(read_dn), 32'd1);
      check_val("write_dn during read", 32'(write_dn), 32'd0);
      check_val("read data", rd_data, mem_model[a]);
    end else begin
      check_val("write_dn", 32'(write_dn), 32'd1);
      check_val("read_dn during write", 32'(read_dn), 32'd0);
      mem_model[a] = d;
    end
  endtask

  task automatic send_msg(input cpu_msg_e m);
    @(posedge clk);
    read_q  <= 1'b0;
    write_q <= 1'b0;
    cpu_e   <= 1'b1;
    cpu_msg <= m;
    if (m == msg_start && m_free > 0) begin
      m_free--;
      m_active++;
    end else if (m == msg_end && m_active > 0) begin
      m_active--;
      m_free++;
      // running index wraps into the smaller active range
      if (m_run >= m_active) begin
        m_run = 0;
      end
    end
    @(posedge clk);
    cpu_e <= 1'b0;
  endtask

  task automatic load_entry(input int k);
    @(posedge clk);
    proc_load  <= 1'b1;
    proc_entry <= ent[`PROC_IDX_W'(k)];
    loaded = k + 1;
  endtask

  initial begin
    int                 i;
    int                 n;
    int                 idx;
    logic [`ADDR_W-1:0] a;
    logic [`DATA_W-1:0] d;
    cpu_msg_e           m;
    seed        = 61;
    ext_rst_e   = 1'b1;
    proc_load   = 1'b0;
    proc_entry  = '0;
    cpu_e       = 1'b0;
    cpu_msg     = msg_none;
    read_q      = 1'b0;
    write_q     = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    m_active    = 0;
    m_free      = `CPU_QUANTITY;
    m_run       = 0;
    m_last_free = 1'b0;
    m_sel       = 0;
    loaded      = 0;
    for (i = 0; i < `PROC_QUANTITY; i++) begin
      ent[`PROC_IDX_W'(i)] = `ADDR_W'($random(seed));
    end

    // test 1 reset and cpu_rst sequence
    @(posedge clk);
    @(negedge clk);
    check_val("cpu_q in reset", 32'(cpu_q), 32'd0);
    check_val("cpu_rst in reset", 32'(cpu_rst), 32'd0);
    check_val("read_dn in reset", 32'(read_dn), 32'd0);
    check_val("write_dn in reset", 32'(write_dn), 32'd0);
    @(posedge clk);
    ext_rst_e <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!cpu_rst && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_rst) begin
      timed_out = 1'b1;
      $display("timeout: cpu_rst never rose after reset");
    end
    for (i = 0; i < `CPU_QUANTITY; i++) begin
      check_val("cpu_rst", 32'(cpu_rst), 32'd1);
      check_val("cpu_rst_idx", 32'(cpu_rst_idx), 32'(i));
      @(negedge clk);
    end
    check_val("cpu_rst after sequence", 32'(cpu_rst), 32'd0);
    n = 0;
    for (i = 0; i < 12; i++) begin
      if (cpu_q) begin
        n++;
      end
      @(negedge clk);
    end
    check_val("offers before any load", 32'(n), 32'd0);
    report_test(1, "reset sequence");

    // test 2 one entry starts the slices and three more join later
    load_entry(0);
    @(posedge clk);
    proc_load <= 1'b0;
    wait_offer();
    check_val("first offer is free", 32'(cpu_active), 32'd0);
    for (i = 1; i < 4; i++) begin
      load_entry(i);
    end
    @(posedge clk);
    proc_load <= 1'b0;
    send_msg(msg_start);
    wait_offer();
    for (i = 0; i < 3; i++) begin
      send_msg(msg_yield);
      wait_offer();
    end
    report_test(2, "free and active alternation");

    // test 3 both cpus running
    send_msg(msg_start);
    wait_offer();
    check_val("offer with all cpus running", 32'(cpu_active), 32'd1);
    for (i = 0; i < 4; i++) begin
      // a start with no free slot must leave the counts alone
      n = int'($unsigned($random(seed)) % 3);
      m = (n == 0) ? msg_start : ((n == 1) ? msg_yield : msg_none);
      send_msg(m);
      wait_offer();
      check_val("offer with all cpus running", 32'(cpu_active), 32'd1);
    end
    report_test(3, "active rotation");

    // test 4 shared memory traffic inside one slice
    for (i = 0; i < 6; i++) begin
      a = `ADDR_W'($random(seed));
      d = $random(seed);
      mem_access(1'b0, 1'b1, a, d);
      addrs.push_back(a);
    end
    for (i = 0; i < 6; i++) begin
      idx = int'($unsigned($random(seed)) % addrs.size());
      mem_access(1'b1, 1'b0, addrs[idx], '0);
    end
    // a read and a write raised together are served read first
    a = addrs[0];
    d = $random(seed);
    mem_access(1'b1, 1'b1, a, d);
    mem_access(1'b0, 1'b1, a, d);
    mem_access(1'b1, 1'b0, a, '0);
    send_msg(msg_yield);
    wait_offer();
    report_test(4, "shared memory access");

    // test 5 one cpu leaves
    send_msg(msg_end);
    wait_offer();
    check_val("offer after end is free", 32'(cpu_active), 32'd0);
    for (i = 0; i < 3; i++) begin
      send_msg(msg_yield);
      wait_offer();
    end
    report_test(5, "cpu end message");

    $display("5 tests, %0d checks, %0d errors, %0d offers", checks, errors, offers);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- cpu_dispatch_top.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module cpu_dispatch_top (
  input  logic                   clk,
  input  logic                   ext_rst_e,
  input  logic                   proc_load,
  input  logic [`ADDR_W-1:0]     proc_entry,
  output logic                   cpu_rst,
  output logic [`CPU_IDX_W-1:0]  cpu_rst_idx,
  output logic                   cpu_q,
  output logic                   cpu_active,
  output logic [`CPU_IDX_W-1:0]  cpu_index,
  output logic [`ADDR_W-1:0]     cpu_entry,
  input  logic                   cpu_e,
  input  dispatch_pkg::cpu_msg_e cpu_msg,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic [`ADDR_W-1:0]     req_addr,
  input  logic [`DATA_W-1:0]     req_wdata,
  output logic                   read_dn,
  output logic                   write_dn,
  output logic [`DATA_W-1:0]     rd_data
);
  import dispatch_pkg::*;

  logic                 slot_next;
  logic                 proc_next;
  logic                 started;
  logic                 ended;
  slot_offer_t          offer;
  logic [`PROC_IDX_W:0] proc_cnt;

  mem_req_if mem_bus ();

  assign cpu_active = offer.active;
  assign cpu_index  = offer.idx;
  assign rd_data    = mem_bus.rdata;

  dispatch_ctl dispatch_ctl_inst (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .proc_cnt    (proc_cnt),
    .cpu_rst     (cpu_rst),
    .cpu_rst_idx (cpu_rst_idx),
    .cpu_q       (cpu_q),
    .read_q      (read_q),
    .write_q     (write_q),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .cpu_e       (cpu_e),
    .cpu_msg     (cpu_msg),
    .read_dn     (read_dn),
    .write_dn    (write_dn),
    .slot_next   (slot_next),
    .proc_next   (proc_next),
    .started     (started),
    .ended       (ended),
    .mem         (mem_bus.ctl)
  );

  cpu_slot_table cpu_slot_table_inst (
    .clk        (clk),
    .ext_rst_e  (ext_rst_e),
    .slot_next  (slot_next),
    .started    (started),
    .ended      (ended),
    .offer      (offer),
    .active_cnt (),
    .free_cnt   ()
  );

  proc_table proc_table_inst (
    .clk        (clk),
    .ext_rst_e  (ext_rst_e),
    .proc_load  (proc_load),
    .proc_entry (proc_entry),
    .proc_next  (proc_next),
    .entry      (cpu_entry),
    .proc_cnt   (proc_cnt)
  );

  shared_mem shared_mem_inst (
    .clk (clk),
    .mem (mem_bus.mem)
  );

endmodule

//--- shared_mem.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module shared_mem (
  input  logic   clk,
  mem_req_if.mem mem
);

  logic [`DATA_W-1:0] words [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem.wr) begin
      words[mem.addr] <= mem.wdata;
    end
  end

  // rdata holds the last read word until the next read
  always_ff @(posedge clk) begin
    if (mem.rd) begin
      mem.rdata <= words[mem.addr];
    end
  end

  // done trails every strobe by one cycle
  always_ff @(posedge clk) begin
    mem.done <= mem.rd | mem.wr;
  end

endmodule

//--- proc_table.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module proc_table (
  input  logic                 clk,
  input  logic                 ext_rst_e,
  input  logic                 proc_load,
  input  logic [`ADDR_W-1:0]   proc_entry,
  input  logic                 proc_next,
  output logic [`ADDR_W-1:0]   entry,
  output logic [`PROC_IDX_W:0] proc_cnt
);

  logic [`ADDR_W-1:0]     tbl [`PROC_QUANTITY];
  logic [`PROC_IDX_W-1:0] sel;
  logic [`PROC_IDX_W:0]   sel_inc;
  logic                   do_load;

  // loads past a full table are dropped
  assign do_load = proc_load && (proc_cnt < `PROC_QUANTITY);
  assign sel_inc = {1'b0, sel} + 1'b1;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      proc_cnt <= '0;
      sel      <= '0;
    end else begin
      if (do_load) begin
        proc_cnt <= proc_cnt + 1'b1;
      end
      if (proc_next) begin
        sel <= (sel_inc >= proc_cnt) ? '0 : sel_inc[`PROC_IDX_W-1:0];
      end
    end
  end

  // entry shows the selection before the step, so the first offer is entry 0
  always_ff @(posedge clk) begin
    if (do_load) begin
      tbl[proc_cnt[`PROC_IDX_W-1:0]] <= proc_entry;
    end
    if (proc_next) begin
      entry <= tbl[sel];
    end
  end

endmodule

//--- cpu_slot_table.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module cpu_slot_table (
  input  logic                       clk,
  input  logic                       ext_rst_e,
  input  logic                       slot_next,
  input  logic                       started,
  input  logic                       ended,
  output dispatch_pkg::slot_offer_t  offer,
  output logic [`CPU_IDX_W-1:0]      active_cnt,
  output logic [`CPU_IDX_W-1:0]      free_cnt
);
  import dispatch_pkg::*;

  logic [`CPU_IDX_W-1:0] run_idx;
  logic [`CPU_IDX_W:0]   run_inc;
  logic [`CPU_IDX_W-1:0] run_nxt;
  logic                  last_free;
  logic                  give_free;

  // free slots get every other slice, or all of them when none run
  assign give_free = ((free_cnt != '0) && !last_free) || (active_cnt == '0);

  assign run_inc = {1'b0, run_idx} + 1'b1;
  assign run_nxt = (run_inc >= {1'b0, active_cnt}) ? '0 : run_inc[`CPU_IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      offer      <= '0;
      active_cnt <= '0;
      free_cnt   <= `CPU_IDX_W'(`CPU_QUANTITY);
      run_idx    <= '0;
      last_free  <= 1'b0;
    end else if (slot_next) begin
      if (give_free) begin
        offer     <= '{active: 1'b0, idx: '0};
        last_free <= 1'b1;
      end else begin
        offer     <= '{active: 1'b1, idx: run_nxt};
        run_idx   <= run_nxt;
        last_free <= 1'b0;
      end
    end else if (started) begin
      if ((free_cnt != '0) && (active_cnt != `CPU_IDX_W'(`CPU_QUANTITY))) begin
        free_cnt   <= free_cnt - 1'b1;
        active_cnt <= active_cnt + 1'b1;
      end
    end else if (ended) begin
      if (active_cnt != '0) begin
        active_cnt <= active_cnt - 1'b1;
        free_cnt   <= free_cnt + 1'b1;
        // keep the running index inside the shrunk active range
        if (run_idx >= active_cnt - 1'b1) begin
          run_idx <= '0;
        end
      end
    end
  end

  a_cnt_sum: assert property (@(posedge clk) disable iff (ext_rst_e)
    (active_cnt + free_cnt) == `CPU_QUANTITY)
    else $error("active and free slot counts lost a slot");

endmodule

//--- dispatch_ctl.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

module dispatch_ctl (
  input  logic                    clk,
  input  logic                    ext_rst_e,
  input  logic [`PROC_IDX_W:0]    proc_cnt,
  output logic                    cpu_rst,
  output logic [`CPU_IDX_W-1:0]   cpu_rst_idx,
  output logic                    cpu_q,
  input  logic                    read_q,
  input  logic                    write_q,
  input  logic [`ADDR_W-1:0]      req_addr,
  input  logic [`DATA_W-1:0]      req_wdata,
  input  logic                    cpu_e,
  input  dispatch_pkg::cpu_msg_e  cpu_msg,
  output logic                    read_dn,
  output logic                    write_dn,
  output logic                    slot_next,
  output logic                    proc_next,
  output logic                    started,
  output logic                    ended,
  mem_req_if.ctl                  mem
);
  import dispatch_pkg::*;

  ctl_state_e            state;
  logic [`CPU_IDX_W-1:0] rst_cnt;
  logic                  rd_op;
  logic                  msg_op;
  logic                  hold_off;
  logic                  offer_go;

  // both tables step on the edge that raises cpu_q
  assign offer_go  = (state == st_cpu_loop) && (proc_cnt != '0);
  assign slot_next = offer_go;
  assign proc_next = offer_go;

  // a cpu sees cpu_q or a done one cycle late and may still hold
  // the request it was just served for
  assign hold_off = cpu_q | read_dn | write_dn;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state       <= st_reset_wait;
      rst_cnt     <= '0;
      rd_op       <= 1'b0;
      msg_op      <= 1'b0;
      cpu_rst     <= 1'b0;
      cpu_rst_idx <= '0;
      cpu_q       <= 1'b0;
      read_dn     <= 1'b0;
      write_dn    <= 1'b0;
      started     <= 1'b0;
      ended       <= 1'b0;
      mem.rd      <= 1'b0;
      mem.wr      <= 1'b0;
    end else begin
      // strobes last one cycle
      cpu_rst  <= 1'b0;
      cpu_q    <= 1'b0;
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      started  <= 1'b0;
      ended    <= 1'b0;
      mem.rd   <= 1'b0;
      mem.wr   <= 1'b0;
      case (state)
        st_reset_wait: begin
          cpu_rst     <= 1'b1;
          cpu_rst_idx <= rst_cnt;
          if (rst_cnt == `CPU_IDX_W'(`CPU_QUANTITY - 1)) begin
            state <= st_cpu_loop;
          end else begin
            rst_cnt <= rst_cnt + 1'b1;
          end
        end
        st_cpu_loop: begin
          // no offer until at least one process is loaded
          if (offer_go) begin
            cpu_q <= 1'b1;
            state <= st_cpu_cmd;
          end
        end
        st_cpu_cmd: begin
          if (!hold_off) begin
            if (read_q) begin
              mem.rd <= 1'b1;
              rd_op  <= 1'b1;
              state  <= st_mem_work;
            end else if (write_q) begin
              mem.wr <= 1'b1;
              rd_op  <= 1'b0;
              state  <= st_mem_work;
            end else if (cpu_e) begin
              started <= (cpu_msg == msg_start);
              ended   <= (cpu_msg == msg_end);
              msg_op  <= 1'b1;
              state   <= st_mem_work;
            end
          end
        end
        st_mem_work: begin
          // one settle cycle lets the slot table take the message
          if (msg_op) begin
            msg_op <= 1'b0;
            state  <= st_cpu_loop;
          end else if (mem.done) begin
            read_dn  <= rd_op;
            write_dn <= !rd_op;
            state    <= st_cpu_cmd;
          end
        end
        default: state <= st_reset_wait;
      endcase
    end
  end

  // request fields are captured on the edge that takes the request
  always_ff @(posedge clk) begin
    if (state == st_cpu_cmd) begin
      mem.addr  <= req_addr;
      mem.wdata <= req_wdata;
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(mem.rd && mem.wr))
    else $error("shared memory read and write strobes overlap");

  // st_mem_work relies on the memory answering in the next cycle
  a_done_next: assert property (@(posedge clk) disable iff (ext_rst_e)
    (mem.rd || mem.wr) |=> mem.done)
    else $error("shared memory done missing one cycle after a strobe");

endmodule

//--- mem_req_if.sv
`timescale 1ns/1ps
`include "dispatch_macros.svh"

interface mem_req_if;
  logic               rd;
  logic               wr;
  logic [`ADDR_W-1:0] addr;
  logic [`DATA_W-1:0] wdata;
  // rdata is valid in the done cycle of a read
  logic [`DATA_W-1:0] rdata;
  logic               done;

  modport ctl (output rd, wr, addr, wdata, input rdata, done);

  modport mem (input rd, wr, addr, wdata, output rdata, done);

endinterface

//--- dispatch_pkg.sv
`include "dispatch_macros.svh"

package dispatch_pkg;

  // controller phases
  typedef enum logic [1:0] {
    st_reset_wait,
    st_cpu_loop,
    st_cpu_cmd,
    st_mem_work
  } ctl_state_e;

  // message a cpu reports together with cpu_e
  typedef enum logic [1:0] {
    msg_none  = 2'd0,
    msg_start = 2'd1,
    msg_end   = 2'd2,
    msg_yield = 2'd3
  } cpu_msg_e;

  // one slice offer, active low means a free slot
  typedef struct packed {
    logic                  active;
    logic [`CPU_IDX_W-1:0] idx;
  } slot_offer_t;

endpackage

//--- dispatch_macros.svh
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// shared memory and process entry address width
`define ADDR_W 8
`define DATA_W 32

// cpu slots, the slot index is sized to hold the count
`define CPU_QUANTITY 2
`define CPU_IDX_W 2

// process table
`define PROC_QUANTITY 8
`define PROC_IDX_W 3

`define MEM_DEPTH 256

`endif
